//--- sources.f
+incdir+testbench
common/usbDescPkg.sv
ep0/ep0Rom.sv
ep0/setupDecoder.sv
ep0/descStreamer.sv
rtl/ep0DescTop.sv
testbench/ep0DescTb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := ep0DescTb
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail
sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/ep0DescModel.svh
`ifndef EP0_DESC_MODEL_SVH
`define EP0_DESC_MODEL_SVH

// Expected beats of one answer in transfer order
typedef usbDescPkg::TxBeat BeatQueue[$];

// Returns 1 for a request that must stall, otherwise fills beats with the answer
function automatic bit expectedAnswer(input usbDescPkg::SetupPacket setup,
                                      output BeatQueue beats);
    bit accepted;
    int slot;
    int start;
    int total;
    int wLength;
    int sent;
    int romPos;
    usbDescPkg::TxBeat beat;

    beats = {};
    accepted = 1'b0;
    slot = 0;
    if (setup.bmRequestType == 8'h80 && setup.bRequest == usbDescPkg::getDescriptor) begin
        if (setup.descType == usbDescPkg::descTypeDevice && setup.descIndex == 8'd0) begin
            accepted = 1'b1;
            slot = 0;
        end else if (setup.descType == usbDescPkg::descTypeConfig &&
                     int'(setup.descIndex) < usbDescPkg::numConfigs) begin
            accepted = 1'b1;
            slot = 1 + int'(setup.descIndex);
        end else if (setup.descType == usbDescPkg::descTypeString &&
                     int'(setup.descIndex) <= usbDescPkg::numStrings) begin
            accepted = 1'b1;
            slot = 1 + usbDescPkg::numConfigs + int'(setup.descIndex);
        end
    end
    if (!accepted) begin
        return 1'b1;
    end

    start = int'(usbDescPkg::slotStart[slot]);
    total = int'(usbDescPkg::slotLength[slot]);
    wLength = int'({setup.wLengthHi, setup.wLengthLo});
    sent = (wLength < total) ? wLength : total;

    // Image byte 0 is the most significant byte
    for (int i = 0; i < sent; i++) begin
        romPos = usbDescPkg::romSize - 1 - (start + i);
        beat.data = usbDescPkg::romImage[romPos * 8 +: 8];
        beat.last = ((i + 1) % usbDescPkg::maxPacketSize == 0) || (i == sent - 1);
        beat.empty = 1'b0;
        beats.push_back(beat);
    end

    // Short answer that fills its last packet, or no data at all
    if (sent % usbDescPkg::maxPacketSize == 0 && (sent < wLength || sent == 0)) begin
        beat.data = 8'h00;
        beat.last = 1'b1;
        beat.empty = 1'b1;
        beats.push_back(beat);
    end
    return 1'b0;
endfunction

`endif

//--- testbench/ep0DescTb.sv
`timescale 1ns/1ps

module ep0DescTb;

    localparam int setupTimeout = 2000;
    localparam int drainTimeout = 4000;

    logic clk;
    logic rst;
    logic [7:0] setupData;
    logic setupValid;
    logic setupReady;
    usbDescPkg::TxBeat tx;
    logic txValid;
    logic txReady;
    logic stall;

    bit gapsOn;
    bit stallDue;
    usbDescPkg::TxBeat expectedBeats[$];

    `include "ep0DescModel.svh"

    ep0DescTop ep0DescTop_inst (
        .clk        (clk),
        .rst        (rst),
        .setupData  (setupData),
        .setupValid (setupValid),
        .setupReady (setupReady),
        .tx         (tx),
        .txValid    (txValid),
        .txReady    (txReady),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        failRun();
    endtask

    task automatic checkBeat(input usbDescPkg::TxBeat actual, input usbDescPkg::TxBeat expected,
                             input string what);
        // Data of an empty beat carries no meaning
        if (actual.last !== expected.last || actual.empty !== expected.empty ||
            (!expected.empty && actual.data !== expected.data)) begin
            $display("CHECK FAILED at %0t ns: %s, got %02h/%0b/%0b, expected %02h/%0b/%0b",
                     $time, what, actual.data, actual.last, actual.empty,
                     expected.data, expected.last, expected.empty);
            failRun();
        end
    endtask

    task automatic checkStall(input bit actual, input bit expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: stall is %0b, expected %0b", $time, actual, expected);
            failRun();
        end
    endtask

    task automatic checkReady(input logic actual, input bit expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: setupReady is %0b, expected %0b",
                     $time, actual, expected);
            failRun();
        end
    endtask

    function automatic usbDescPkg::SetupPacket makeSetup(input logic [7:0] requestType,
            input logic [7:0] request, input logic [7:0] descType, input logic [7:0] descIndex,
            input logic [15:0] wLength);
        usbDescPkg::SetupPacket setup;
        setup.bmRequestType = requestType;
        setup.bRequest = request;
        setup.descIndex = descIndex;
        setup.descType = descType;
        setup.wIndexLo = 8'h00;
        setup.wIndexHi = 8'h00;
        setup.wLengthLo = wLength[7:0];
        setup.wLengthHi = wLength[15:8];
        return setup;
    endfunction

    // Starts and ends on a rising edge
    task automatic sendSetup(input usbDescPkg::SetupPacket setup);
        logic [63:0] bits;
        bit stallExpected;
        BeatQueue beats;
        int waitCount;
        bits = setup;
        stallExpected = expectedAnswer(setup, beats);
        for (int i = 0; i < 8; i++) begin
            setupData <= bits[63 - 8 * i -: 8];
            setupValid <= 1'b1;
            waitCount = 0;
            @(negedge clk);
            while (!setupReady) begin
                waitCount++;
                if (waitCount > setupTimeout) begin
                    timeoutFail("the decoder never took the next setup byte");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        setupValid <= 1'b0;
        foreach (beats[k]) begin
            expectedBeats.push_back(beats[k]);
        end
        // Decision shows one cycle after the eighth byte
        stallDue = stallExpected;
        @(negedge clk);
        // Decoder stops collecting once the packet is complete
        checkReady(setupReady, 1'b0);
        @(posedge clk);
        stallDue = 1'b0;
    endtask

    task automatic requestDesc(input logic [7:0] descType, input logic [7:0] descIndex,
                               input logic [15:0] wLength);
        sendSetup(makeSetup(8'h80, usbDescPkg::getDescriptor, descType, descIndex, wLength));
    endtask

    task automatic waitDrained();
        int waitCount;
        waitCount = 0;
        while (expectedBeats.size() != 0) begin
            waitCount++;
            if (waitCount > drainTimeout) begin
                timeoutFail("the DUT never sent all expected beats");
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic setGaps(input bit on);
        @(negedge clk);
        gapsOn = on;
        @(posedge clk);
    endtask

    // Sink side with optional random stalls
    initial begin
        txReady = 1'b0;
        forever begin
            @(posedge clk);
            if (gapsOn) begin
                txReady <= ($urandom_range(0, 2) != 0);
            end else begin
                txReady <= 1'b1;
            end
        end
    end

    // Outputs are sampled on the falling edge, between updates
    initial begin : compareProcess
        usbDescPkg::TxBeat heldBeat;
        bit holding;
        holding = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                checkStall(stall, stallDue);
                if (txValid && holding) begin
                    checkBeat(tx, heldBeat, "beat changed while txReady was low");
                end
                if (txValid && expectedBeats.size() == 0) begin
                    $display("Error at %0t ns: the DUT sent a beat that no request asked for",
                             $time);
                    failRun();
                end else if (txValid && txReady) begin
                    checkBeat(tx, expectedBeats.pop_front(), "wrong beat");
                    holding = 1'b0;
                end else if (txValid) begin
                    heldBeat = tx;
                    holding = 1'b1;
                end
            end
        end
    end

    initial begin : mainSequence
        int kind;
        int length;
        void'($urandom(32'h091ec455));
        rst = 1'b1;
        setupData = 8'h00;
        setupValid = 1'b0;
        gapsOn = 1'b0;
        stallDue = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        requestDesc(usbDescPkg::descTypeDevice, 8'd0, 16'd64);
        waitDrained();
        requestDesc(usbDescPkg::descTypeConfig, 8'd0, 16'd9);
        waitDrained();
        requestDesc(usbDescPkg::descTypeConfig, 8'd0, 16'd255);
        waitDrained();
        for (int s = 0; s <= usbDescPkg::numStrings + 1; s++) begin
            requestDesc(usbDescPkg::descTypeString, 8'(s), 16'd255);
            waitDrained();
        end

        // Vendor request, SET_ADDRESS and a missing configuration
        sendSetup(makeSetup(8'hC0, usbDescPkg::getDescriptor, usbDescPkg::descTypeDevice,
                            8'd0, 16'd18));
        sendSetup(makeSetup(8'h80, 8'h05, usbDescPkg::descTypeDevice, 8'd0, 16'd18));
        requestDesc(usbDescPkg::descTypeConfig, 8'(usbDescPkg::numConfigs), 16'd255);
        requestDesc(usbDescPkg::descTypeDevice, 8'd0, 16'd18);
        waitDrained();

        setGaps(1'b1);
        requestDesc(usbDescPkg::descTypeConfig, 8'd0, 16'd255);
        requestDesc(usbDescPkg::descTypeDevice, 8'd0, 16'd64);
        requestDesc(usbDescPkg::descTypeString, 8'd2, 16'd255);
        waitDrained();

        // Back to back while earlier answers still stream
        for (int n = 0; n < 24; n++) begin
            kind = $urandom_range(0, 2);
            length = (n == 7) ? 0 : $urandom_range(0, 40);
            if (kind == 0) begin
                requestDesc(usbDescPkg::descTypeDevice, 8'd0, 16'(length));
            end else if (kind == 1) begin
                requestDesc(usbDescPkg::descTypeConfig, 8'd0, 16'(length));
            end else begin
                requestDesc(usbDescPkg::descTypeString,
                            8'($urandom_range(0, usbDescPkg::numStrings)), 16'(length));
            end
        end
        waitDrained();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- rtl/ep0DescTop.sv
`timescale 1ns/1ps

module ep0DescTop (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        setupData,
    input  logic              setupValid,
    output logic              setupReady,
    output usbDescPkg::TxBeat tx,
    output logic              txValid,
    input  logic              txReady,
    output logic              stall
);

    usbDescPkg::DescRequest req;
    logic reqValid;
    logic reqReady;
    logic [usbDescPkg::slotWidth-1:0] slotSel;
    logic [usbDescPkg::romIdxWidth-1:0] romAddr;
    logic [7:0] romData;
    logic [usbDescPkg::romIdxWidth-1:0] slotStartAddr;
    logic [15:0] slotLen;

    setupDecoder setupDecoder_inst (
        .clk        (clk),
        .rst        (rst),
        .setupData  (setupData),
        .setupValid (setupValid),
        .setupReady (setupReady),
        .req        (req),
        .reqValid   (reqValid),
        .reqReady   (reqReady),
        .stall      (stall)
    );

    ep0Rom ep0Rom_inst (
        .slotSel       (slotSel),
        .romAddr       (romAddr),
        .romData       (romData),
        .slotStartAddr (slotStartAddr),
        .slotLen       (slotLen)
    );

    descStreamer descStreamer_inst (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .reqValid      (reqValid),
        .reqReady      (reqReady),
        .slotSel       (slotSel),
        .romAddr       (romAddr),
        .romData       (romData),
        .slotStartAddr (slotStartAddr),
        .slotLen       (slotLen),
        .tx            (tx),
        .txValid       (txValid),
        .txReady       (txReady)
    );

endmodule

//--- ep0/descStreamer.sv
`timescale 1ns/1ps

module descStreamer (
    input  logic                               clk,
    input  logic                               rst,
    input  usbDescPkg::DescRequest             req,
    input  logic                               reqValid,
    output logic                               reqReady,
    output logic [usbDescPkg::slotWidth-1:0]   slotSel,
    output logic [usbDescPkg::romIdxWidth-1:0] romAddr,
    input  logic [7:0]                         romData,
    input  logic [usbDescPkg::romIdxWidth-1:0] slotStartAddr,
    input  logic [15:0]                        slotLen,
    output usbDescPkg::TxBeat                  tx,
    output logic                               txValid,
    input  logic                               txReady
);

    typedef enum logic [1:0] {
        idle,
        sendData,
        sendEmpty
    } StreamState;

    StreamState state;
    logic [usbDescPkg::slotWidth-1:0] slotReg;
    logic [usbDescPkg::romIdxWidth-1:0] curAddr;
    logic [15:0] remaining;
    logic [usbDescPkg::packetPosWidth-1:0] pktPos;
    logic emptyAfter;
    logic [15:0] sentLen;
    logic accept;
    logic beatDone;
    logic finalByte;
    logic packetFull;

    assign reqReady = (state == idle);
    assign accept = reqValid && reqReady;
    assign txValid = (state != idle);
    assign beatDone = txValid && txReady;

    // The host never gets more than it asked for
    assign sentLen = (req.wLength < slotLen) ? req.wLength : slotLen;

    // Slot lookup follows the incoming request while idle
    assign slotSel = (state == idle) ? req.slot : slotReg;
    assign romAddr = curAddr;

    assign finalByte = (remaining == 16'd1);
    assign packetFull = (pktPos == usbDescPkg::packetPosWidth'(usbDescPkg::maxPacketSize - 1));

    always_comb begin
        case (state)
            sendData: begin
                tx.data = romData;
                tx.last = packetFull || finalByte;
                tx.empty = 1'b0;
            end
            sendEmpty: begin
                tx.data = 8'h00;
                tx.last = 1'b1;
                tx.empty = 1'b1;
            end
            default: begin
                tx.data = 8'h00;
                tx.last = 1'b0;
                tx.empty = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            remaining <= 16'd0;
            pktPos <= '0;
            emptyAfter <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= (sentLen == 16'd0) ? sendEmpty : sendData;
                        remaining <= sentLen;
                        pktPos <= '0;
                        // Short answer ending on a full packet needs a ZLP
                        emptyAfter <= (sentLen[usbDescPkg::packetPosWidth-1:0] == '0) &&
                            (sentLen < req.wLength);
                    end
                end
                sendData: begin
                    if (beatDone) begin
                        if (finalByte) begin
                            state <= emptyAfter ? sendEmpty : idle;
                        end else begin
                            remaining <= remaining - 16'd1;
                            pktPos <= pktPos + 1'b1;
                        end
                    end
                end
                sendEmpty: begin
                    if (beatDone) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slotReg <= req.slot;
            curAddr <= slotStartAddr;
        end else if (state == sendData && beatDone && !finalByte) begin
            curAddr <= curAddr + 1'b1;
        end
    end

endmodule

//--- ep0/setupDecoder.sv
`timescale 1ns/1ps

module setupDecoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             setupData,
    input  logic                   setupValid,
    output logic                   setupReady,
    output usbDescPkg::DescRequest req,
    output logic                   reqValid,
    input  logic                   reqReady,
    output logic                   stall
);

    typedef enum logic [1:0] {
        collecting,
        rejecting,
        holding
    } DecoderState;

    DecoderState state;
    logic [2:0] byteCount;
    logic byteTaken;
    logic lastByte;
    usbDescPkg::SetupPacket packet;
    usbDescPkg::SetupPacket nextPacket;
    logic requestOk;
    logic [usbDescPkg::slotWidth-1:0] slot;

    assign setupReady = (state == collecting);
    assign reqValid = (state == holding);
    assign stall = (state == rejecting);

    assign byteTaken = setupValid && setupReady;
    assign lastByte = byteTaken && (byteCount == 3'd7);

    // Bytes shift in from the right so bmRequestType ends on top
    assign nextPacket = {packet[55:0], setupData};

    // Check the full packet as the eighth byte arrives
    always_comb begin
        requestOk = 1'b0;
        slot = '0;
        if (nextPacket.bmRequestType == usbDescPkg::reqTypeStdDevIn &&
            nextPacket.bRequest == usbDescPkg::getDescriptor) begin
            case (nextPacket.descType)
                usbDescPkg::descTypeDevice: begin
                    requestOk = (nextPacket.descIndex == 8'd0);
                    slot = '0;
                end
                usbDescPkg::descTypeConfig: begin
                    requestOk = (int'(nextPacket.descIndex) < usbDescPkg::numConfigs);
                    slot = usbDescPkg::slotWidth'(1 + int'(nextPacket.descIndex));
                end
                usbDescPkg::descTypeString: begin
                    requestOk = (int'(nextPacket.descIndex) <= usbDescPkg::numStrings);
                    slot = usbDescPkg::slotWidth'(1 + usbDescPkg::numConfigs
                        + int'(nextPacket.descIndex));
                end
                default: begin
                    requestOk = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= collecting;
            byteCount <= '0;
        end else begin
            case (state)
                collecting: begin
                    if (byteTaken) begin
                        byteCount <= byteCount + 3'd1;
                    end
                    if (lastByte) begin
                        state <= requestOk ? holding : rejecting;
                    end
                end
                // Stall lasts exactly one cycle
                rejecting: state <= collecting;
                holding: begin
                    if (reqReady) begin
                        state <= collecting;
                    end
                end
                default: state <= collecting;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byteTaken) begin
            packet <= nextPacket;
        end
        if (lastByte) begin
            req.slot <= slot;
            req.wLength <= {nextPacket.wLengthHi, nextPacket.wLengthLo};
        end
    end

endmodule

//--- ep0/ep0Rom.sv
`timescale 1ns/1ps

module ep0Rom (
    input  logic [usbDescPkg::slotWidth-1:0]   slotSel,
    input  logic [usbDescPkg::romIdxWidth-1:0] romAddr,
    output logic [7:0]                         romData,
    output logic [usbDescPkg::romIdxWidth-1:0] slotStartAddr,
    output logic [15:0]                        slotLen
);

    logic [7:0] romBytes [usbDescPkg::romSize];
    logic [usbDescPkg::romIdxWidth-1:0] startTable [usbDescPkg::numSlots];
    logic [15:0] lengthTable [usbDescPkg::numSlots];
    logic addrInRange;
    logic slotInRange;

    // Descriptor bytes unpacked from the image
    for (genvar i = 0; i < usbDescPkg::romSize; i++) begin : fillRom
        assign romBytes[i] = usbDescPkg::romByte(i);
    end

    // Start and length of each descriptor slot
    for (genvar s = 0; s < usbDescPkg::numSlots; s++) begin : fillSlots
        assign startTable[s] = usbDescPkg::slotStart[s];
        assign lengthTable[s] = usbDescPkg::slotLength[s];
    end

    assign addrInRange = (int'(romAddr) < usbDescPkg::romSize);
    assign slotInRange = (int'(slotSel) < usbDescPkg::numSlots);

    // Addresses past the image read as zero
    always_comb begin
        if (addrInRange) begin
            romData = romBytes[romAddr];
        end else begin
            romData = 8'h00;
        end
    end

    // Unused slot codes give an empty descriptor at address 0
    always_comb begin
        if (slotInRange) begin
            slotStartAddr = startTable[slotSel];
            slotLen = lengthTable[slotSel];
        end else begin
            slotStartAddr = '0;
            slotLen = 16'd0;
        end
    end

endmodule

//--- common/usbDescPkg.sv
package usbDescPkg;

    // Endpoint 0 runs at full speed with 8 byte packets
    localparam int maxPacketSize = 8;
    localparam int packetPosWidth = $clog2(maxPacketSize);

    // Standard request codes
    localparam logic [7:0] reqTypeStdDevIn = 8'h80;
    localparam logic [7:0] getDescriptor = 8'h06;

    // Descriptor type codes
    localparam logic [7:0] descTypeDevice = 8'h01;
    localparam logic [7:0] descTypeConfig = 8'h02;
    localparam logic [7:0] descTypeString = 8'h03;
    localparam logic [7:0] descTypeInterface = 8'h04;
    localparam logic [7:0] descTypeEndpoint = 8'h05;

    localparam int numConfigs = 1;
    localparam int numStrings = 2;

    // Descriptor sizes in bytes
    localparam int devDescLen = 18;
    localparam int cfgDescLen = 9;
    localparam int ifaceDescLen = 9;
    localparam int epDescLen = 7;
    localparam int cfgTotalLen = cfgDescLen + ifaceDescLen + 2 * epDescLen;
    localparam int str0Len = 4;
    localparam int str1Len = 2 + 2 * 3;
    localparam int str2Len = 2 + 2 * 7;

    localparam logic [15:0] vendorId = 16'hC0DE;
    localparam logic [15:0] productId = 16'h0E01;

    // Every descriptor is written with its first byte leftmost
    localparam logic [devDescLen*8-1:0] devDesc = {
        8'(devDescLen), descTypeDevice, 8'h00, 8'h02,
        8'h00, 8'h00, 8'h00, 8'(maxPacketSize),
        vendorId[7:0], vendorId[15:8], productId[7:0], productId[15:8],
        8'h00, 8'h01, 8'h01, 8'h02, 8'h00, 8'(numConfigs)
    };

    // Bus powered, 100 mA
    localparam logic [cfgDescLen*8-1:0] cfgDesc = {
        8'(cfgDescLen), descTypeConfig, 8'(cfgTotalLen), 8'(cfgTotalLen >> 8),
        8'h01, 8'h01, 8'h00, 8'h80, 8'h32
    };

    // Vendor specific interface with one bulk pair
    localparam logic [ifaceDescLen*8-1:0] ifaceDesc = {
        8'(ifaceDescLen), descTypeInterface, 8'h00, 8'h00,
        8'h02, 8'hFF, 8'h00, 8'h00, 8'h00
    };

    localparam logic [epDescLen*8-1:0] epInDesc = {
        8'(epDescLen), descTypeEndpoint, 8'h81, 8'h02, 8'h40, 8'h00, 8'h00
    };

    localparam logic [epDescLen*8-1:0] epOutDesc = {
        8'(epDescLen), descTypeEndpoint, 8'h02, 8'h02, 8'h40, 8'h00, 8'h00
    };

    // Language list holds US English only
    localparam logic [str0Len*8-1:0] str0Desc = {
        8'(str0Len), descTypeString, 8'h09, 8'h04
    };

    // Strings are UTF-16LE
    localparam logic [str1Len*8-1:0] str1Desc = {
        8'(str1Len), descTypeString, "L", 8'h00, "a", 8'h00, "b", 8'h00
    };

    localparam logic [str2Len*8-1:0] str2Desc = {
        8'(str2Len), descTypeString, "E", 8'h00, "p", 8'h00, "0", 8'h00,
        " ", 8'h00, "R", 8'h00, "o", 8'h00, "m", 8'h00
    };

    localparam int romSize = devDescLen + cfgTotalLen + str0Len + str1Len + str2Len;
    localparam int romIdxWidth = $clog2(romSize);

    // Byte 0 of the ROM sits in the top byte
    localparam logic [romSize*8-1:0] romImage = {
        devDesc, cfgDesc, ifaceDesc, epInDesc, epOutDesc, str0Desc, str1Desc, str2Desc
    };

    // Slot order is device, configurations, then strings from index 0
    localparam int numSlots = 2 + numConfigs + numStrings;
    localparam int slotWidth = $clog2(numSlots);

    localparam int devStart = 0;
    localparam int cfgStart = devStart + devDescLen;
    localparam int str0Start = cfgStart + cfgTotalLen;
    localparam int str1Start = str0Start + str0Len;
    localparam int str2Start = str1Start + str1Len;

    localparam logic [romIdxWidth-1:0] slotStart [numSlots] = '{
        romIdxWidth'(devStart), romIdxWidth'(cfgStart), romIdxWidth'(str0Start),
        romIdxWidth'(str1Start), romIdxWidth'(str2Start)
    };

    // A configuration slot covers its whole block
    localparam logic [15:0] slotLength [numSlots] = '{
        16'(devDescLen), 16'(cfgTotalLen), 16'(str0Len), 16'(str1Len), 16'(str2Len)
    };

    // Setup fields in wire order
    typedef struct packed {
        logic [7:0] bmRequestType;
        logic [7:0] bRequest;
        logic [7:0] descIndex;
        logic [7:0] descType;
        logic [7:0] wIndexLo;
        logic [7:0] wIndexHi;
        logic [7:0] wLengthLo;
        logic [7:0] wLengthHi;
    } SetupPacket;

    typedef struct packed {
        logic [slotWidth-1:0] slot;
        logic [15:0] wLength;
    } DescRequest;

    // empty marks a zero-length packet and always comes with last
    typedef struct packed {
        logic [7:0] data;
        logic last;
        logic empty;
    } TxBeat;

    function automatic logic [7:0] romByte(input int index);
        return romImage[(romSize - 1 - index) * 8 +: 8];
    endfunction

endpackage
